// File: sources.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_issue.sv
rtl/lsu_data_mem.sv
rtl/lsu_load_return.sv
rtl/lsu_top.sv
sim/lsu_asserts.sv
sim/tb_lsu.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_lsu \
    -f sources.f \
    -o tb_lsu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/tb_lsu_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: sim/tb_lsu.sv
// Directed tests; memory words are only loaded after the testbench has written them
`include "lsu_cfg.svh"

module tb_lsu;

    localparam int          REGION   = 4 * `LSU_MEM_WORDS;
    localparam logic [31:0] BASE     = `LSU_MEM_BASE;
    localparam int          MAX_WAIT = 200;

    logic               clk;
    logic               rst;
    lsu_pkg::lsu_req_t  req;
    logic               req_valid;
    logic               req_ready;
    lsu_pkg::lsu_resp_t resp;
    logic               resp_valid;
    logic               resp_ready;

    // Reference memory, indexed by byte offset into the region
    logic [7:0]         ref_mem [REGION];
    lsu_pkg::lsu_resp_t exp_q [$];
    lsu_pkg::lsu_resp_t got_q [$];
    logic [31:0]        stored_addr [$];
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    bit                 timed_out;
    logic [3:0]         next_tag;

    lsu_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Record every response transfer
    always @(posedge clk) begin
        if (!rst && resp_valid && resp_ready) begin
            got_q.push_back(resp);
        end
    end

    function automatic lsu_pkg::lsu_req_t make_req(input logic [31:0] base,
            input logic [11:0] offset, input logic [31:0] wdata,
            input lsu_pkg::size_t size, input bit is_store, input bit is_unsigned);
        lsu_pkg::lsu_req_t r;
        r.base        = base;
        r.offset      = offset;
        r.wdata       = wdata;
        r.size        = size;
        r.is_store    = is_store;
        r.is_unsigned = is_unsigned;
        r.tag         = next_tag;
        next_tag      = next_tag + 4'd1;
        return r;
    endfunction

    // Applies the access to the reference memory; returns 1 if a response is due
    function automatic bit model_access(input lsu_pkg::lsu_req_t r,
            output lsu_pkg::lsu_resp_t e);
        logic [31:0]     ea;
        logic [31:0]     word;
        int              off;
        int              nbytes;
        bit              mis;
        bit              oor;
        lsu_pkg::fault_t code;
        ea     = r.base + {{20{r.offset[11]}}, r.offset};
        nbytes = 1 << int'(r.size);
        mis    = (ea % nbytes) != 0;
        oor    = (ea < BASE) || (ea >= BASE + REGION);
        if (r.is_store && (mis || oor)) code = lsu_pkg::FAULT_ST;
        else if (mis) code = lsu_pkg::FAULT_LD_MISALIGN;
        else if (oor) code = lsu_pkg::FAULT_LD_ACCESS;
        else code = lsu_pkg::FAULT_NONE;
        e.tag      = r.tag;
        e.is_fault = code != lsu_pkg::FAULT_NONE;
        if (e.is_fault) begin
            e.word.fault.code    = code;
            e.word.fault.tval_hi = ea[31:2];
            return 1'b1;
        end
        off = int'(ea - BASE);
        if (r.is_store) begin
            for (int i = 0; i < nbytes; i++) ref_mem[off + i] = r.wdata[8*i +: 8];
            return 1'b0;
        end
        word = '0;
        for (int i = 0; i < nbytes; i++) word[8*i +: 8] = ref_mem[off + i];
        if (!r.is_unsigned && nbytes == 1 && word[7]) word[31:8] = '1;
        if (!r.is_unsigned && nbytes == 2 && word[15]) word[31:16] = '1;
        e.word.data = word;
        return 1'b1;
    endfunction

    // Starts and ends on a falling edge
    task automatic send(input lsu_pkg::lsu_req_t r);
        lsu_pkg::lsu_resp_t e;
        int                 cycles;
        if (timed_out) return;
        if (model_access(r, e)) exp_q.push_back(e);
        req       = r;
        req_valid = 1'b1;
        cycles    = 0;
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > MAX_WAIT) begin
                $display("Timeout: request tag %0d never accepted", r.tag);
                timed_out = 1'b1;
                req_valid = 1'b0;
                return;
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Waits for all expected responses and compares them in order
    task automatic drain_and_check();
        int cycles;
        cycles = 0;
        while (!timed_out && got_q.size() < exp_q.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_WAIT) begin
                $display("Timeout: %0d of %0d responses arrived", got_q.size(), exp_q.size());
                timed_out = 1'b1;
            end
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            if (got_q[0] !== exp_q[0]) begin
                $display("Fail at time %0t: got tag %0d fault %0b word %h, want %0d %0b %h",
                    $time, got_q[0].tag, got_q[0].is_fault, got_q[0].word.data,
                    exp_q[0].tag, exp_q[0].is_fault, exp_q[0].word.data);
                errors++;
            end
            void'(got_q.pop_front());
            void'(exp_q.pop_front());
        end
        if (got_q.size() > 0) begin
            $display("Fail at time %0t: %0d unexpected responses", $time, got_q.size());
            errors++;
            got_q.delete();
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        drain_and_check();
        tests_run++;
        if (errors != errors_before || timed_out) begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic word_test();
        int          e0;
        logic [31:0] ea;
        logic [11:0] off;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            ea  = BASE + 4 * $urandom_range(0, `LSU_MEM_WORDS - 1);
            off = 12'($urandom()) & 12'hffc;
            stored_addr.push_back(ea);
            send(make_req(ea - {{20{off[11]}}, off}, off, $urandom(), lsu_pkg::SIZE_W, 1, 0));
        end
        foreach (stored_addr[i]) begin
            off = 12'($urandom()) | 12'h800;
            off = off & 12'hffc;
            send(make_req(stored_addr[i] - {{20{off[11]}}, off}, off, '0,
                lsu_pkg::SIZE_W, 0, 0));
        end
        finish_test("word accesses", e0);
    endtask

    task automatic partial_test();
        int          e0;
        logic [31:0] wbase;
        e0    = errors;
        wbase = BASE + 32'h40;
        send(make_req(wbase, 12'd0, 32'h8f7e_06c5, lsu_pkg::SIZE_W, 1, 0));
        send(make_req(wbase, 12'd1, $urandom() | 32'h80, lsu_pkg::SIZE_B, 1, 0));
        send(make_req(wbase, 12'd2, $urandom() & 32'h7fff, lsu_pkg::SIZE_H, 1, 0));
        for (int b = 0; b < 4; b++) begin
            send(make_req(wbase, 12'(b), '0, lsu_pkg::SIZE_B, 0, 0));
            send(make_req(wbase, 12'(b), '0, lsu_pkg::SIZE_B, 0, 1));
        end
        for (int h = 0; h < 4; h += 2) begin
            send(make_req(wbase, 12'(h), '0, lsu_pkg::SIZE_H, 0, 0));
            send(make_req(wbase, 12'(h), '0, lsu_pkg::SIZE_H, 0, 1));
        end
        send(make_req(wbase, 12'd0, '0, lsu_pkg::SIZE_W, 0, 0));
        finish_test("partial stores", e0);
    endtask

    task automatic misaligned_test();
        int e0;
        e0 = errors;
        send(make_req(BASE + 32'h80, 12'd1, '0, lsu_pkg::SIZE_H, 0, 0));
        send(make_req(BASE + 32'h80, 12'd2, '0, lsu_pkg::SIZE_W, 0, 0));
        send(make_req(BASE + 32'h44, 12'hfff, '0, lsu_pkg::SIZE_W, 0, 0));
        send(make_req(BASE + 32'h40, 12'd1, $urandom(), lsu_pkg::SIZE_W, 1, 0));
        send(make_req(BASE + 32'h40, 12'd3, $urandom(), lsu_pkg::SIZE_H, 1, 0));
        // Word must be untouched by the faulting stores
        send(make_req(BASE + 32'h40, 12'd0, '0, lsu_pkg::SIZE_W, 0, 0));
        finish_test("misaligned access", e0);
    endtask

    task automatic range_test();
        int e0;
        e0 = errors;
        send(make_req(BASE, 12'hffc, '0, lsu_pkg::SIZE_W, 0, 0));
        send(make_req(BASE + REGION, 12'd0, '0, lsu_pkg::SIZE_W, 0, 0));
        send(make_req(32'h0, 12'd8, '0, lsu_pkg::SIZE_B, 0, 0));
        send(make_req(BASE + REGION - 4, 12'd4, $urandom(), lsu_pkg::SIZE_W, 1, 0));
        // Good and faulting loads back to back
        send(make_req(stored_addr[0], 12'd0, '0, lsu_pkg::SIZE_W, 0, 0));
        send(make_req(32'hffff_fff0, 12'd0, '0, lsu_pkg::SIZE_W, 0, 0));
        send(make_req(stored_addr[1], 12'd0, '0, lsu_pkg::SIZE_W, 0, 0));
        send(make_req(BASE + 32'h42, 12'd0, '0, lsu_pkg::SIZE_W, 0, 0));
        send(make_req(BASE + 32'h40, 12'd2, '0, lsu_pkg::SIZE_H, 0, 1));
        finish_test("out-of-range access", e0);
    endtask

    task automatic backpressure_test();
        int                 e0;
        int                 accepted;
        bit                 blocked;
        lsu_pkg::lsu_req_t  r;
        lsu_pkg::lsu_resp_t e;
        e0         = errors;
        accepted   = 0;
        blocked    = 1'b0;
        resp_ready = 1'b0;
        while (!timed_out && !blocked && accepted < 8) begin
            r         = make_req(stored_addr[accepted % stored_addr.size()], 12'd0, '0,
                lsu_pkg::SIZE_W, 0, 0);
            req       = r;
            req_valid = 1'b1;
            #1;
            if (req_ready) begin
                void'(model_access(r, e));
                exp_q.push_back(e);
                accepted++;
                @(negedge clk);
            end else begin
                blocked = 1'b1;
            end
        end
        req_valid = 1'b0;
        repeat (3) @(negedge clk);
        if (!blocked) begin
            $display("Fail at time %0t: req_ready never fell under back-pressure", $time);
            errors++;
        end
        if (accepted > `LSU_ATTR_DEPTH + 1) begin
            $display("Fail at time %0t: %0d loads accepted while stalled", $time, accepted);
            errors++;
        end
        if (got_q.size() != 0 || !resp_valid) begin
            $display("Fail at time %0t: response not held while resp_ready low", $time);
            errors++;
        end
        resp_ready = 1'b1;
        finish_test("back-pressure", e0);
    endtask

    initial begin
        void'($urandom(32'h06e4_d38c));
        rst          = 1'b1;
        req          = '0;
        req_valid    = 1'b0;
        resp_ready   = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        next_tag     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        word_test();
        partial_test();
        misaligned_test();
        range_test();
        backpressure_test();

        $display("Tests run %0d, failed %0d, errors %0d, timeout %0d",
            tests_run, tests_failed, errors, timed_out);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: sim/lsu_asserts.sv
// Bound to lsu_top; sampled on the rising clock edge and quiet while reset is high
module lsu_asserts (
    input logic               clk,
    input logic               rst,
    input logic               req_valid,
    input logic               req_ready,
    input lsu_pkg::lsu_resp_t resp,
    input logic               resp_valid,
    input logic               resp_ready,
    input lsu_pkg::mem_op_t   op,
    input logic               op_valid
);

    // First edge after reset sees no response
    resp_idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !resp_valid)
        else $error("response valid right after reset");

    // Stalled response keeps its payload
    resp_held_stable: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response changed while stalled");

    // Good stores leave the issue register at once unless a new request replaces them
    store_never_blocked: assert property (@(posedge clk) disable iff (rst)
        op_valid && op.is_store && op.fault == lsu_pkg::FAULT_NONE
            && !(req_valid && req_ready) |=> !op_valid)
        else $error("non-faulting store held back by memory");

endmodule

bind lsu_top lsu_asserts i_asserts (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .op         (op),
    .op_valid   (op_valid)
);

// File: rtl/lsu_top.sv
// One outstanding request in issue plus LSU_ATTR_DEPTH responses past the memory
module lsu_top (
    input  logic               clk,
    input  logic               rst,

    input  lsu_pkg::lsu_req_t  req,
    input  logic               req_valid,
    output logic               req_ready,

    output lsu_pkg::lsu_resp_t resp,
    output logic               resp_valid,
    input  logic               resp_ready
);

    // Issue to memory
    lsu_pkg::mem_op_t    op;
    logic                op_valid;
    logic                op_ready;
    lsu_pkg::load_attr_t issue_attr;

    // Memory to return
    logic                attr_push;
    lsu_pkg::load_attr_t push_attr;
    logic                attr_full;
    logic                rdata_valid;
    lsu_pkg::resp_word_u rdata;

    //////////////////////////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////////////////////////

    lsu_issue i_issue (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .op        (op),
        .op_valid  (op_valid),
        .attr      (issue_attr),
        .op_ready  (op_ready)
    );

    lsu_data_mem i_mem (
        .clk         (clk),
        .op          (op),
        .op_valid    (op_valid),
        .attr_in     (issue_attr),
        .op_ready    (op_ready),
        .attr_full   (attr_full),
        .attr_push   (attr_push),
        .attr_out    (push_attr),
        .rdata_valid (rdata_valid),
        .rdata       (rdata)
    );

    lsu_load_return i_return (
        .clk         (clk),
        .rst         (rst),
        .attr_push   (attr_push),
        .attr_in     (push_attr),
        .attr_full   (attr_full),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .resp        (resp),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready)
    );

endmodule

// File: rtl/lsu_load_return.sv
// In-order return of loads and faults; both queues share one read pointer and LSU_ATTR_DEPTH
`include "lsu_cfg.svh"

module lsu_load_return (
    input  logic                clk,
    input  logic                rst,

    input  logic                attr_push,
    input  lsu_pkg::load_attr_t attr_in,
    output logic                attr_full,

    input  logic                rdata_valid,
    input  lsu_pkg::resp_word_u rdata,

    output lsu_pkg::lsu_resp_t  resp,
    output logic                resp_valid,
    input  logic                resp_ready
);

    localparam int DEPTH = `LSU_ATTR_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    lsu_pkg::load_attr_t attr_q [DEPTH];
    lsu_pkg::resp_word_u data_q [DEPTH];

    logic [PW-1:0]        attr_wr_ptr;
    logic [PW-1:0]        data_wr_ptr;
    logic [PW-1:0]        rd_ptr;
    logic [CW-1:0]        attr_cnt;
    logic [CW-1:0]        data_cnt;
    logic                 pop;
    lsu_pkg::load_attr_t  head_attr;
    lsu_pkg::resp_word_u  head_word;
    logic [7:0]           byte_lane;
    logic [15:0]          half_lane;
    logic                 sign_b;
    logic                 sign_h;
    logic [`LSU_XLEN-1:0] load_data;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        if (p == PW'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Attribute FIFO and read-data queue
    //////////////////////////////////////////////////////////////////////

    // Attribute count is the credit towards the memory
    assign attr_full = attr_cnt == CW'(DEPTH);
    assign pop       = resp_valid && resp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            attr_wr_ptr <= '0;
            data_wr_ptr <= '0;
            rd_ptr      <= '0;
            attr_cnt    <= '0;
            data_cnt    <= '0;
        end else begin
            if (attr_push) begin
                attr_wr_ptr <= next_ptr(attr_wr_ptr);
            end
            if (rdata_valid) begin
                data_wr_ptr <= next_ptr(data_wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            attr_cnt <= attr_cnt + CW'(attr_push) - CW'(pop);
            data_cnt <= data_cnt + CW'(rdata_valid) - CW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (attr_push) begin
            attr_q[attr_wr_ptr] <= attr_in;
        end
        if (rdata_valid) begin
            data_q[data_wr_ptr] <= rdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Head entry alignment
    //////////////////////////////////////////////////////////////////////

    // Empty queue means the head word is arriving this cycle
    assign head_attr = attr_q[rd_ptr];
    assign head_word = (data_cnt == '0) ? rdata : data_q[rd_ptr];

    assign byte_lane = head_word.data[8*head_attr.byte_off +: 8];
    assign half_lane = head_word.data[16*head_attr.byte_off[1] +: 16];
    assign sign_b    = !head_attr.is_unsigned && byte_lane[7];
    assign sign_h    = !head_attr.is_unsigned && half_lane[15];

    always_comb begin
        case (head_attr.size)
            lsu_pkg::SIZE_B: load_data = {{(`LSU_XLEN-8){sign_b}}, byte_lane};
            lsu_pkg::SIZE_H: load_data = {{(`LSU_XLEN-16){sign_h}}, half_lane};
            default:         load_data = head_word.data;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////

    assign resp_valid = (data_cnt != '0) || rdata_valid;

    always_comb begin
        resp.tag      = head_attr.tag;
        resp.is_fault = head_attr.fault != lsu_pkg::FAULT_NONE;
        if (resp.is_fault) begin
            // Fault info travels unchanged
            resp.word = head_word;
        end else begin
            resp.word.data = load_data;
        end
    end

endmodule

// File: rtl/lsu_data_mem.sv
// Single-port word memory with one-cycle read; contents are undefined until written
`include "lsu_cfg.svh"

module lsu_data_mem (
    input  logic                clk,

    input  lsu_pkg::mem_op_t    op,
    input  logic                op_valid,
    input  lsu_pkg::load_attr_t attr_in,
    output logic                op_ready,

    input  logic                attr_full,
    output logic                attr_push,
    output lsu_pkg::load_attr_t attr_out,

    output logic                rdata_valid,
    output lsu_pkg::resp_word_u rdata
);

    localparam int LANES = `LSU_XLEN / 8;

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

    logic no_fault;
    logic accept;
    logic do_write;
    logic do_read;

    //////////////////////////////////////////////////////////////////////
    // Flow control
    //////////////////////////////////////////////////////////////////////

    assign no_fault = op.fault == lsu_pkg::FAULT_NONE;

    // Good stores leave no response, so they need no credit
    assign op_ready = !attr_full || (op.is_store && no_fault);
    assign accept   = op_valid && op_ready;

    assign do_write = accept && op.is_store && no_fault;
    assign do_read  = accept && !op.is_store && no_fault;

    assign attr_push = accept && !(op.is_store && no_fault);
    assign attr_out  = attr_in;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int i = 0; i < LANES; i++) begin
                if (op.be[i]) begin
                    mem[op.word_addr][8*i +: 8] <= op.wdata[8*i +: 8];
                end
            end
        end
    end

    // Load word or fault info, one cycle after acceptance
    always_ff @(posedge clk) begin
        if (do_read) begin
            rdata.data <= mem[op.word_addr];
        end else if (attr_push) begin
            rdata.fault.code    <= op.fault;
            rdata.fault.tval_hi <= op.tval[`LSU_XLEN-1:2];
        end
    end

    // Valid one cycle after each attribute push
    always_ff @(posedge clk) begin
        rdata_valid <= attr_push;
    end

endmodule

// File: rtl/lsu_issue.sv
// Offset is the 12-bit immediate; misalignment takes priority over a range fault on loads
`include "lsu_cfg.svh"

module lsu_issue (
    input  logic                clk,
    input  logic                rst,

    input  lsu_pkg::lsu_req_t   req,
    input  logic                req_valid,
    output logic                req_ready,

    output lsu_pkg::mem_op_t    op,
    output logic                op_valid,
    output lsu_pkg::load_attr_t attr,
    input  logic                op_ready
);

    localparam logic [`LSU_XLEN-1:0] REGION_BYTES = `LSU_XLEN'(4 * `LSU_MEM_WORDS);

    logic [`LSU_XLEN-1:0] ea;
    logic [`LSU_XLEN-1:0] region_off;
    logic                 misaligned;
    logic                 out_of_range;
    lsu_pkg::fault_t      fault;
    logic [3:0]           size_be;
    logic                 accept;
    lsu_pkg::mem_op_t     op_d;
    lsu_pkg::load_attr_t  attr_d;

    //////////////////////////////////////////////////////////////////////
    // Address generation and checks
    //////////////////////////////////////////////////////////////////////

    assign ea = req.base + {{(`LSU_XLEN-12){req.offset[11]}}, req.offset};

    // Single unsigned compare also catches addresses below the base
    assign region_off   = ea - `LSU_MEM_BASE;
    assign out_of_range = region_off >= REGION_BYTES;

    always_comb begin
        case (req.size)
            lsu_pkg::SIZE_B: misaligned = 1'b0;
            lsu_pkg::SIZE_H: misaligned = ea[0];
            default:         misaligned = |ea[1:0];
        endcase
    end

    always_comb begin
        if (req.is_store && (misaligned || out_of_range)) begin
            fault = lsu_pkg::FAULT_ST;
        end else if (misaligned) begin
            fault = lsu_pkg::FAULT_LD_MISALIGN;
        end else if (out_of_range) begin
            fault = lsu_pkg::FAULT_LD_ACCESS;
        end else begin
            fault = lsu_pkg::FAULT_NONE;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Byte lanes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req.size)
            lsu_pkg::SIZE_B: size_be = 4'b0001;
            lsu_pkg::SIZE_H: size_be = 4'b0011;
            default:         size_be = 4'b1111;
        endcase
    end

    always_comb begin
        op_d.word_addr = region_off[lsu_pkg::MEM_AW+1:2];
        // No lanes enabled for an access that must not reach memory
        op_d.be        = (fault == lsu_pkg::FAULT_NONE) ? (size_be << ea[1:0]) : 4'b0000;
        op_d.wdata     = req.wdata << {ea[1:0], 3'b000};
        op_d.is_store  = req.is_store;
        op_d.fault     = fault;
        op_d.tval      = ea;

        attr_d.tag         = req.tag;
        attr_d.byte_off    = ea[1:0];
        attr_d.size        = req.size;
        attr_d.is_unsigned = req.is_unsigned;
        attr_d.fault       = fault;
    end

    //////////////////////////////////////////////////////////////////////
    // Request register
    //////////////////////////////////////////////////////////////////////

    assign req_ready = !op_valid || op_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (accept) begin
            op_valid <= 1'b1;
        end else if (op_ready) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op   <= op_d;
            attr <= attr_d;
        end
    end

endmodule

// File: rtl/lsu_pkg.sv
// Shared types for the load/store unit; response word layout assumes LSU_XLEN of 32
`include "lsu_cfg.svh"

package lsu_pkg;

    // Word address width of the data memory
    localparam int MEM_AW = $clog2(`LSU_MEM_WORDS);

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Low two bits of the RISC-V load/store funct3
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } size_t;

    // Stores share one code for misaligned and out-of-range
    typedef enum logic [1:0] {
        FAULT_NONE         = 2'b00,
        FAULT_LD_MISALIGN  = 2'b01,
        FAULT_LD_ACCESS    = 2'b10,
        FAULT_ST           = 2'b11
    } fault_t;

    //////////////////////////////////////////////////////////////////////
    // Transfers
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`LSU_XLEN-1:0] base;
        logic signed [11:0]   offset;
        logic [`LSU_XLEN-1:0] wdata;
        size_t                size;
        logic                 is_store;
        logic                 is_unsigned;
        logic [3:0]           tag;
    } lsu_req_t;

    // Store data already sits in its byte lanes
    typedef struct packed {
        logic [MEM_AW-1:0]    word_addr;
        logic [3:0]           be;
        logic [`LSU_XLEN-1:0] wdata;
        logic                 is_store;
        fault_t               fault;
        logic [`LSU_XLEN-1:0] tval;
    } mem_op_t;

    typedef struct packed {
        logic [3:0] tag;
        logic [1:0] byte_off;
        size_t      size;
        logic       is_unsigned;
        fault_t     fault;
    } load_attr_t;

    // Fault view of the response word, code in the top bits
    typedef struct packed {
        fault_t               code;
        logic [`LSU_XLEN-3:0] tval_hi;
    } fault_info_t;

    typedef union packed {
        logic [`LSU_XLEN-1:0] data;
        fault_info_t          fault;
    } resp_word_u;

    typedef struct packed {
        logic [3:0] tag;
        logic       is_fault;
        resp_word_u word;
    } lsu_resp_t;

endpackage

// File: rtl/lsu_cfg.svh
// Sizes assume a 32-bit data word, a power-of-two memory depth and a word-aligned region base
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////////////////////////

// Width of data and address words
`define LSU_XLEN 32

//////////////////////////////////////////////////////////////////////
// Data memory region
//////////////////////////////////////////////////////////////////////

// Words held by the on-chip data memory
`define LSU_MEM_WORDS 256

// Byte address of the first word; the region spans 4 * LSU_MEM_WORDS bytes
`define LSU_MEM_BASE 32'h0000_1000

//////////////////////////////////////////////////////////////////////
// Response tracking
//////////////////////////////////////////////////////////////////////

// Loads and faults that may be in flight past the memory
`define LSU_ATTR_DEPTH 2

`endif
